// File: rv_isa_pkg.sv
package rv_isa_pkg;

	localparam int xlen = 32;

	// major opcodes, instr[6:0]
	typedef enum logic [6:0] {
		R     = 7'b0110011,	// register-register alu
		I     = 7'b0010011,	// register-immediate alu
		B     = 7'b1100011,	// conditional branch
		LUI   = 7'b0110111,
		AUIPC = 7'b0010111,
		JAL   = 7'b1101111,
		JALR  = 7'b1100111,
		LOAD  = 7'b0000011,
		STORE = 7'b0100011,
		MEM   = 7'b0001111,	// fence
		SYS   = 7'b1110011	// ecall, ebreak, csr
	} opcode_t;

	typedef logic [2:0] funct3_t;

	// R-type codes
	localparam funct3_t ADD   = 3'b000;
	localparam funct3_t SUB   = 3'b000;	// told apart by instr[30]
	localparam funct3_t SLL   = 3'b001;
	localparam funct3_t SLT   = 3'b010;
	localparam funct3_t SLTU  = 3'b011;
	localparam funct3_t XOR   = 3'b100;
	localparam funct3_t SRL   = 3'b101;
	localparam funct3_t SRA   = 3'b101;	// told apart by instr[30]
	localparam funct3_t OR    = 3'b110;
	localparam funct3_t AND   = 3'b111;

	// I-type aliases, same encodings
	localparam funct3_t ADDI  = 3'b000;
	localparam funct3_t SLLI  = 3'b001;
	localparam funct3_t SLTI  = 3'b010;
	localparam funct3_t SLTIU = 3'b011;
	localparam funct3_t XORI  = 3'b100;
	localparam funct3_t SRLI  = 3'b101;
	localparam funct3_t SRAI  = 3'b101;
	localparam funct3_t ORI   = 3'b110;
	localparam funct3_t ANDI  = 3'b111;

	// instr[30] picks the right-shift kind
	typedef enum logic {
		logical    = 1'b0,
		arithmetic = 1'b1
	} shift_type_t;

	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		funct3_t    funct3;
		logic [4:0] rd;
		opcode_t    opcode;
	} instr_t;

endpackage

// File: exec_pkg.sv
package exec_pkg;

	typedef logic [rv_isa_pkg::xlen-1:0] data_t;

	localparam data_t null_word = '0;

	// accepted with the issue strobe
	typedef struct packed {
		rv_isa_pkg::instr_t instr;
		data_t              pc;
	} issue_t;

	// registered writeback record
	typedef struct packed {
		logic       valid;
		logic [4:0] rd;
		data_t      data;
	} wb_t;

	// effective address out for loads and stores
	typedef struct packed {
		logic  valid;
		logic  write;	// 1 for store
		data_t addr;
		data_t wdata;
	} mem_req_t;

endpackage

// File: exec_ctrl.sv
`timescale 1ns/1ps

module exec_ctrl (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 issue_valid,
	input  exec_pkg::issue_t     issue,
	input  exec_pkg::data_t      rs1_data,
	input  exec_pkg::data_t      rs2_data,
	input  exec_pkg::data_t      imm,
	input  exec_pkg::data_t      c_out,
	input  logic                 rd_wr,

	output rv_isa_pkg::instr_t   cur_instr,
	output logic [4:0]           rs1_idx,
	output logic [4:0]           rs2_idx,
	output exec_pkg::data_t      a_in,
	output exec_pkg::data_t      b_in,
	output logic                 rf_we,
	output logic [4:0]           rf_waddr,
	output exec_pkg::data_t      rf_wdata,
	output exec_pkg::wb_t        wb,
	output exec_pkg::mem_req_t   mem_req
);

	import rv_isa_pkg::*;
	import exec_pkg::*;

	issue_t  issue_q;
	logic    valid_q;
	opcode_t opcode;
	logic    is_load;
	logic    is_store;
	logic    wr_en;
	logic    mem_en;

	// issue register, one instruction held for the execute cycle
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			valid_q <= 1'b0;
			issue_q <= '0;
		end else begin
			valid_q <= issue_valid;
			if (issue_valid) begin
				issue_q <= issue;
			end
		end
	end

	assign cur_instr = issue_q.instr;
	assign opcode    = issue_q.instr.opcode;
	assign rs1_idx   = issue_q.instr.rs1;
	assign rs2_idx   = issue_q.instr.rs2;

	always_comb begin : operand_sel
		case (opcode)
			R: begin
				a_in = rs1_data;
				b_in = rs2_data;
			end
			I, LOAD, STORE: begin
				a_in = rs1_data;
				b_in = imm;
			end
			LUI: begin
				a_in = null_word;
				b_in = imm;	// alu passes b_in through
			end
			AUIPC: begin
				a_in = issue_q.pc;
				b_in = imm;
			end
			JAL, JALR: begin
				a_in = issue_q.pc;
				b_in = data_t'(4);	// link address
			end
			default: begin
				a_in = rs1_data;
				b_in = rs2_data;
			end
		endcase
	end

	assign is_load  = (opcode == LOAD);
	assign is_store = (opcode == STORE);

	// loads have no memory behind them, x0 never written
	assign wr_en  = valid_q && rd_wr && !is_load && (issue_q.instr.rd != 5'd0);
	assign mem_en = valid_q && (is_load || is_store);

	assign rf_we    = wr_en;
	assign rf_waddr = issue_q.instr.rd;
	assign rf_wdata = c_out;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wb      <= '0;
			mem_req <= '0;
		end else begin
			wb.valid <= wr_en;
			if (wr_en) begin
				wb.rd   <= issue_q.instr.rd;
				wb.data <= c_out;
			end
			mem_req.valid <= mem_en;
			if (mem_en) begin
				mem_req.write <= is_store;
				mem_req.addr  <= c_out;	// rs1 + imm
				mem_req.wdata <= is_store ? rs2_data : null_word;
			end
		end
	end

endmodule

// File: imm_gen.sv
`timescale 1ns/1ps

module imm_gen (
	input  rv_isa_pkg::instr_t instr,
	output exec_pkg::data_t    imm
);

	import rv_isa_pkg::*;
	import exec_pkg::*;

	always_comb begin
		case (instr.opcode)
			I, LOAD, JALR: begin	// I format
				imm = {{20{instr[31]}}, instr[31:20]};
			end
			STORE: begin	// S format
				imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
			end
			B: begin
				imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
					instr[11:8], 1'b0};
			end
			LUI, AUIPC: begin	// U format, low 12 bits zero
				imm = {instr[31:12], 12'b0};
			end
			JAL: begin
				imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
					instr[30:21], 1'b0};
			end
			default: begin
				imm = null_word;	// R, fence, system
			end
		endcase
	end

endmodule

// File: regfile.sv
`timescale 1ns/1ps

module regfile #(
	parameter int nregs = 32
) (
	input  logic            clk,
	input  logic            rst_n,
	input  logic [4:0]      rs1_idx,
	input  logic [4:0]      rs2_idx,
	input  logic            we,
	input  logic [4:0]      waddr,
	input  exec_pkg::data_t wdata,

	output exec_pkg::data_t rs1_data,
	output exec_pkg::data_t rs2_data
);

	import exec_pkg::*;

	data_t regs [1:nregs-1];	// x0 has no storage

	// indices outside 1..nregs-1 fall through to zero
	function automatic data_t read_reg(input logic [4:0] idx);
		data_t val;
		val = null_word;
		for (int i = 1; i < nregs; i++) begin
			if (idx == 5'(i)) begin
				val = regs[i];
			end
		end
		return val;
	endfunction

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 1; i < nregs; i++) begin
				regs[i] <= null_word;
			end
		end else begin
			for (int i = 1; i < nregs; i++) begin
				if (we && waddr == 5'(i)) begin
					regs[i] <= wdata;
				end
			end
		end
	end

	assign rs1_data = read_reg(rs1_idx);
	assign rs2_data = read_reg(rs2_idx);

endmodule

// File: alu.sv
`timescale 1ns/1ps

module alu (
	input  rv_isa_pkg::instr_t instr,
	input  exec_pkg::data_t    a_in,
	input  exec_pkg::data_t    b_in,
	input  exec_pkg::data_t    imm,

	output exec_pkg::data_t    c_out,
	output logic               rd_wr
);

	import rv_isa_pkg::*;
	import exec_pkg::*;

	opcode_t     opcode;
	funct3_t     funct3;
	shift_type_t shift_type;
	logic [4:0]  shamt;
	logic        sub_func;
	data_t       opnd_b;	// second operand, imm for I-type

	data_t and_result;
	data_t or_result;
	data_t xor_result;
	data_t set_result;
	data_t shift_result;
	data_t add_sub_result;

	data_t adder_b;
	logic  lt_signed;
	logic  lt_unsigned;
	logic  set_flag;

	always_comb begin : decode
		opcode     = instr.opcode;
		funct3     = instr.funct3;
		shift_type = shift_type_t'(instr[30]);
		sub_func   = (opcode == R) && instr[30] && (funct3 == SUB);
		shamt      = (opcode == I) ? instr.rs2 : b_in[4:0];
		opnd_b     = (opcode == I) ? imm : b_in;
	end

	assign and_result = a_in & opnd_b;
	assign or_result  = a_in | opnd_b;
	assign xor_result = a_in ^ opnd_b;

	always_comb begin : shifter
		case ({shift_type, funct3})
			{logical, SLL}:    shift_result = a_in << shamt;
			{logical, SRL}:    shift_result = a_in >> shamt;
			{arithmetic, SRA}: shift_result = $signed(a_in) >>> shamt;
			default:           shift_result = null_word;
		endcase
	end

	// a - b = a + ~b + 1
	always_comb begin : add_suber
		adder_b        = sub_func ? ~opnd_b : opnd_b;
		add_sub_result = a_in + adder_b + data_t'(sub_func);
	end

	always_comb begin : seter
		lt_signed   = $signed(a_in) < $signed(opnd_b);
		lt_unsigned = a_in < opnd_b;
		set_flag    = ((funct3 == SLT) && lt_signed) || ((funct3 == SLTU) && lt_unsigned);
		set_result  = {{(xlen-1){1'b0}}, set_flag};
	end

	always_comb begin : output_sel
		c_out = null_word;
		rd_wr = 1'b0;
		case (opcode)
			R: begin
				case (funct3)
					ADD:       c_out = add_sub_result;	// SUB too
					SLL:       c_out = shift_result;
					SLT, SLTU: c_out = set_result;
					XOR:       c_out = xor_result;
					SRL:       c_out = shift_result;	// SRA too
					OR:        c_out = or_result;
					AND:       c_out = and_result;
					default:   c_out = null_word;
				endcase
				rd_wr = 1'b1;
			end
			I: begin
				case (funct3)
					ADDI:        c_out = add_sub_result;
					SLLI:        c_out = shift_result;
					SLTI, SLTIU: c_out = set_result;
					XORI:        c_out = xor_result;
					SRLI:        c_out = shift_result;	// SRAI too
					ORI:         c_out = or_result;
					ANDI:        c_out = and_result;
					default:     c_out = null_word;
				endcase
				rd_wr = 1'b1;
			end
			LUI: begin
				c_out = b_in;	// already the shifted immediate
				rd_wr = 1'b1;
			end
			AUIPC, JAL, JALR, LOAD: begin
				c_out = add_sub_result;
				rd_wr = 1'b1;
			end
			STORE: begin
				c_out = add_sub_result;	// address only
				rd_wr = 1'b0;
			end
			B, MEM, SYS: begin
				c_out = null_word;
				rd_wr = 1'b0;
			end
			default: begin
				c_out = null_word;
				rd_wr = 1'b0;
			end
		endcase
	end

endmodule

// File: exec_core.sv
`timescale 1ns/1ps

module exec_core #(
	parameter int nregs = 32
) (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               issue_valid,
	input  exec_pkg::issue_t   issue,

	output exec_pkg::wb_t      wb,
	output exec_pkg::mem_req_t mem_req
);

	import rv_isa_pkg::*;
	import exec_pkg::*;

	instr_t     cur_instr;
	logic [4:0] rs1_idx;
	logic [4:0] rs2_idx;
	data_t      rs1_data;
	data_t      rs2_data;
	data_t      imm;
	data_t      a_in;
	data_t      b_in;
	data_t      c_out;
	logic       rd_wr;
	logic       rf_we;
	logic [4:0] rf_waddr;
	data_t      rf_wdata;

	exec_ctrl i_exec_ctrl (
		.clk         (clk),
		.rst_n       (rst_n),
		.issue_valid (issue_valid),
		.issue       (issue),
		.rs1_data    (rs1_data),
		.rs2_data    (rs2_data),
		.imm         (imm),
		.c_out       (c_out),
		.rd_wr       (rd_wr),
		.cur_instr   (cur_instr),
		.rs1_idx     (rs1_idx),
		.rs2_idx     (rs2_idx),
		.a_in        (a_in),
		.b_in        (b_in),
		.rf_we       (rf_we),
		.rf_waddr    (rf_waddr),
		.rf_wdata    (rf_wdata),
		.wb          (wb),
		.mem_req     (mem_req)
	);

	imm_gen i_imm_gen (
		.instr (cur_instr),
		.imm   (imm)
	);

	regfile #(
		.nregs (nregs)
	) i_regfile (
		.clk      (clk),
		.rst_n    (rst_n),
		.rs1_idx  (rs1_idx),
		.rs2_idx  (rs2_idx),
		.we       (rf_we),
		.waddr    (rf_waddr),
		.wdata    (rf_wdata),
		.rs1_data (rs1_data),
		.rs2_data (rs2_data)
	);

	alu i_alu (
		.instr (cur_instr),
		.a_in  (a_in),
		.b_in  (b_in),
		.imm   (imm),
		.c_out (c_out),
		.rd_wr (rd_wr)
	);

endmodule

// File: tb_exec_core.sv
`timescale 1ns/1ps

module tb_exec_core;

	import rv_isa_pkg::*;
	import exec_pkg::*;

	// cycle budget per test is one per issued instruction plus one to drain
	localparam int reset_cycles = 3;
	localparam int n_reset_test = 1 + 1;
	localparam int n_rtype      = 11 * 2 + 6 * 10 + 1;
	localparam int n_itype      = 6 * 5 + 3 * 32 + 1;
	localparam int n_pc_rel     = 4 * 4 + 1;
	localparam int n_no_write   = 12 + 1;
	localparam int n_chain      = 2 + 16 + 1;
	localparam int total_cycles = reset_cycles + n_reset_test + n_rtype + n_itype
		+ n_pc_rel + n_no_write + n_chain;
	localparam int timeout_ns   = total_cycles * 10 + 500;

	logic     clk;
	logic     rst_n;
	logic     issue_valid;
	issue_t   issue;
	wb_t      wb;
	mem_req_t mem_req;

	data_t       model_regs [32];	// reference register file
	data_t       cur_pc;
	logic [31:0] lfsr_state;
	logic        pend_valid;	// result of the last issue still in flight
	string       pend_name;
	wb_t         pend_wb;
	mem_req_t    pend_mem;

	exec_core #(
		.nregs (32)
	) i_exec_core (
		.clk         (clk),
		.rst_n       (rst_n),
		.issue_valid (issue_valid),
		.issue       (issue),
		.wb          (wb),
		.mem_req     (mem_req)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	initial begin : watchdog
		#(timeout_ns);
		fail_run("timeout: the tests did not finish in the expected time");
	end

	task automatic fail_run(input string reason);
		$display("%s", reason);
		$display("Some tests failed");
		$fatal(1, "stopped at the first error");
	endtask

	// galois lfsr with taps 32 22 2 1
	function automatic logic lfsr_bit();
		logic out;
		out = lfsr_state[0];
		lfsr_state = lfsr_state >> 1;
		if (out)
			lfsr_state = lfsr_state ^ 32'h8020_0003;
		return out;
	endfunction

	function automatic data_t rand_word(input int nbits);
		data_t val;
		val = null_word;
		for (int i = 0; i < nbits; i++)
			val = {val[30:0], lfsr_bit()};
		return val;
	endfunction

	function automatic data_t sext12(input data_t v);
		return {{20{v[11]}}, v[11:0]};
	endfunction

	function automatic instr_t r_type(input logic [6:0] f7, input logic [4:0] rs2,
		input logic [4:0] rs1, input funct3_t f3, input logic [4:0] rd);
		return instr_t'({f7, rs2, rs1, f3, rd, R});
	endfunction

	function automatic instr_t i_type(input opcode_t op, input data_t imm, input logic [4:0] rs1,
		input funct3_t f3, input logic [4:0] rd);
		return instr_t'({imm[11:0], rs1, f3, rd, op});
	endfunction

	function automatic instr_t s_type(input data_t imm, input logic [4:0] rs2,
		input logic [4:0] rs1, input funct3_t f3);
		return instr_t'({imm[11:5], rs2, rs1, f3, imm[4:0], STORE});
	endfunction

	function automatic instr_t b_type(input data_t imm, input logic [4:0] rs2,
		input logic [4:0] rs1, input funct3_t f3);
		return instr_t'({imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], B});
	endfunction

	function automatic instr_t u_type(input opcode_t op, input data_t imm, input logic [4:0] rd);
		return instr_t'({imm[31:12], rd, op});
	endfunction

	function automatic instr_t j_type(input data_t imm, input logic [4:0] rd);
		return instr_t'({imm[20], imm[10:1], imm[11], imm[19:12], rd, JAL});
	endfunction

	// applies rv32i semantics and updates the model registers
	task automatic predict_result(input instr_t ins, input data_t imm,
		output wb_t exp_wb, output mem_req_t exp_mem);
		data_t r1;
		data_t r2;
		data_t b;
		data_t res;
		logic  writes;
		r1      = model_regs[ins.rs1];
		r2      = model_regs[ins.rs2];
		b       = (ins.opcode == R) ? r2 : imm;
		res     = null_word;
		writes  = 1'b0;
		exp_mem = '0;
		case (ins.opcode)
			R, I: begin
				writes = 1'b1;
				case (ins.funct3)
					ADD:  res = (ins.opcode == R && ins.funct7[5]) ? r1 - b : r1 + b;
					SLL:  res = r1 << b[4:0];
					SLT:  res = {31'b0, $signed(r1) < $signed(b)};
					SLTU: res = {31'b0, r1 < b};
					XOR:  res = r1 ^ b;
					SRL: begin
						if (ins.funct7[5])	// bit 30 selects arithmetic
							res = $signed(r1) >>> b[4:0];
						else
							res = r1 >> b[4:0];
					end
					OR:   res = r1 | b;
					AND:  res = r1 & b;
					default: res = null_word;
				endcase
			end
			LUI: begin
				res    = imm;
				writes = 1'b1;
			end
			AUIPC: begin
				res    = cur_pc + imm;
				writes = 1'b1;
			end
			JAL, JALR: begin
				res    = cur_pc + 32'd4;
				writes = 1'b1;
			end
			LOAD: begin
				exp_mem.valid = 1'b1;
				exp_mem.addr  = r1 + imm;
			end
			STORE: begin
				exp_mem.valid = 1'b1;
				exp_mem.write = 1'b1;
				exp_mem.addr  = r1 + imm;
				exp_mem.wdata = r2;
			end
			default: writes = 1'b0;	// branch, fence, system
		endcase
		exp_wb.valid = writes && (ins.rd != 5'd0);
		exp_wb.rd    = ins.rd;
		exp_wb.data  = res;
		if (exp_wb.valid)
			model_regs[ins.rd] = res;
	endtask

	task automatic compare_wb(input string name, input wb_t exp, input wb_t act);
		if (exp.valid !== act.valid || (exp.valid && (exp.rd !== act.rd
			|| exp.data !== act.data))) begin
			fail_run($sformatf("MISMATCH %s wb expected valid=%0b rd=%0d data=%h, %s",
				name, exp.valid, exp.rd, exp.data, $sformatf("actual valid=%0b rd=%0d data=%h",
				act.valid, act.rd, act.data)));
		end
	endtask

	task automatic compare_mem(input string name, input mem_req_t exp, input mem_req_t act);
		if (exp.valid !== act.valid || (exp.valid && (exp.write !== act.write
			|| exp.addr !== act.addr || exp.wdata !== act.wdata))) begin
			fail_run($sformatf("MISMATCH %s mem_req expected %0b/%0b/%h/%h, actual %0b/%0b/%h/%h",
				name, exp.valid, exp.write, exp.addr, exp.wdata,
				act.valid, act.write, act.addr, act.wdata));
		end
	endtask

	task automatic check_pending();
		if (pend_valid) begin
			compare_wb(pend_name, pend_wb, wb);
			compare_mem(pend_name, pend_mem, mem_req);
		end
	endtask

	// one instruction per cycle with the result checked at the next step
	task automatic issue_step(input string name, input instr_t ins, input data_t imm);
		wb_t      exp_wb;
		mem_req_t exp_mem;
		predict_result(ins, imm, exp_wb, exp_mem);
		issue_valid = 1'b1;
		issue.instr = ins;
		issue.pc    = cur_pc;
		cur_pc      = cur_pc + 32'd4;
		@(posedge clk);
		#1;
		check_pending();
		pend_valid = 1'b1;
		pend_name  = name;
		pend_wb    = exp_wb;
		pend_mem   = exp_mem;
	endtask

	task automatic drain();
		issue_valid = 1'b0;
		@(posedge clk);
		#1;
		check_pending();
		pend_valid = 1'b0;
	endtask

	// lui then addi where the low part sign-extends
	task automatic load_reg(input string name, input logic [4:0] rd, input data_t val);
		data_t hi;
		data_t lo;
		hi = (val + 32'h800) & 32'hffff_f000;
		lo = val - hi;
		issue_step(name, u_type(LUI, hi, rd), hi);
		issue_step(name, i_type(I, lo, rd, ADDI, rd), lo);
	endtask

	task automatic reset_state();
		wb_t      zero_wb;
		mem_req_t zero_mem;
		zero_wb  = '0;
		zero_mem = '0;
		compare_wb("reset_state", zero_wb, wb);
		compare_mem("reset_state", zero_mem, mem_req);
		issue_step("reset_state", r_type(7'h00, 5'd2, 5'd1, ADD, 5'd3), null_word);
		drain();
	endtask

	task automatic seed_and_rtype();
		funct3_t    ops_f3 [10] = '{ADD, SUB, AND, OR, XOR, SLL, SRL, SRA, SLT, SLTU};
		logic [6:0] ops_f7 [10] = '{7'h00, 7'h20, 7'h00, 7'h00, 7'h00,
			7'h00, 7'h00, 7'h20, 7'h00, 7'h00};
		logic [4:0] src_a [6] = '{5'd1, 5'd3, 5'd9, 5'd10, 5'd9, 5'd11};
		logic [4:0] src_b [6] = '{5'd2, 5'd4, 5'd10, 5'd9, 5'd11, 5'd10};
		int         k;
		k = 0;
		for (int r = 1; r <= 8; r++)
			load_reg("seed", 5'(r), rand_word(32));
		load_reg("seed", 5'd9, 32'h8000_0000);	// signed corners
		load_reg("seed", 5'd10, 32'h7fff_ffff);
		load_reg("seed", 5'd11, 32'hffff_ffff);
		for (int p = 0; p < 6; p++) begin
			for (int o = 0; o < 10; o++) begin
				issue_step("rtype", r_type(ops_f7[o], src_b[p], src_a[p], ops_f3[o],
					5'(12 + k % 16)), null_word);
				k++;
			end
		end
		drain();
	endtask

	task automatic itype_ops();
		funct3_t    ops_f3 [6] = '{ADDI, ANDI, ORI, XORI, SLTI, SLTIU};
		logic [4:0] srcs [4]   = '{5'd1, 5'd9, 5'd10, 5'd11};
		data_t      imms [5];
		int         k;
		k = 0;
		imms = '{32'hffff_ffff, 32'hffff_f800, 32'h0000_07ff, 32'hffff_fffb, null_word};
		imms[4] = sext12(rand_word(12));
		for (int o = 0; o < 6; o++) begin
			for (int m = 0; m < 5; m++) begin
				issue_step("itype", i_type(I, imms[m], srcs[(o + m) % 4], ops_f3[o],
					5'(12 + k % 16)), imms[m]);
				k++;
			end
		end
		for (int s = 0; s < 32; s++) begin
			issue_step("slli", i_type(I, data_t'(s), 5'd1, SLLI, 5'd12), data_t'(s));
			issue_step("srli", i_type(I, data_t'(s), 5'd9, SRLI, 5'd13), data_t'(s));
			issue_step("srai", i_type(I, 32'h400 | data_t'(s), 5'd9, SRAI, 5'd14),
				32'h400 | data_t'(s));
		end
		drain();
	endtask

	task automatic pc_relative();
		data_t u;
		data_t jimm;
		data_t jr;
		for (int i = 0; i < 4; i++) begin
			u = rand_word(20) << 12;
			issue_step("lui", u_type(LUI, u, 5'd12), u);
			u = rand_word(20) << 12;
			issue_step("auipc", u_type(AUIPC, u, 5'd13), u);
			jimm = rand_word(20);
			jimm = {{11{jimm[19]}}, jimm[19:0], 1'b0};
			issue_step("jal", j_type(jimm, 5'd14), jimm);
			jr = sext12(rand_word(12));
			issue_step("jalr", i_type(JALR, jr, 5'd1, 3'b000, 5'd15), jr);
		end
		drain();
	endtask

	task automatic no_write_ops();
		issue_step("load", i_type(LOAD, 32'hffff_fff0, 5'd1, 3'b010, 5'd12), 32'hffff_fff0);
		issue_step("load", i_type(LOAD, 32'h0000_07fc, 5'd9, 3'b010, 5'd13), 32'h0000_07fc);
		issue_step("store", s_type(32'hffff_ff80, 5'd2, 5'd1, 3'b010), 32'hffff_ff80);
		issue_step("store", s_type(32'h0000_0010, 5'd11, 5'd10, 3'b010), 32'h0000_0010);
		issue_step("branch", b_type(32'd16, 5'd2, 5'd1, 3'b000), 32'd16);
		issue_step("branch", b_type(32'hffff_fff0, 5'd2, 5'd1, 3'b001), 32'hffff_fff0);
		issue_step("fence", i_type(MEM, 32'h0ff, 5'd0, 3'b000, 5'd16), 32'h0ff);
		issue_step("csrrw", i_type(SYS, 32'h300, 5'd1, 3'b001, 5'd7), 32'h300);
		issue_step("ecall", i_type(SYS, null_word, 5'd0, 3'b000, 5'd0), null_word);
		issue_step("x0_write", i_type(I, 32'd5, 5'd1, ADDI, 5'd0), 32'd5);
		issue_step("x0_write", r_type(7'h00, 5'd2, 5'd1, ADD, 5'd0), null_word);
		issue_step("x0_read", r_type(7'h00, 5'd0, 5'd0, ADD, 5'd6), null_word);
		drain();
	endtask

	// each instruction reads the result written one cycle earlier
	task automatic dependency_chain();
		data_t seed;
		seed = sext12(rand_word(12));
		issue_step("chain", i_type(I, seed, 5'd0, ADDI, 5'd20), seed);
		issue_step("chain", i_type(I, 32'd3, 5'd20, ADDI, 5'd21), 32'd3);
		for (int i = 0; i < 16; i++) begin
			case (i % 4)
				0: issue_step("chain", r_type(7'h00, 5'd21, 5'd20, ADD, 5'd20), null_word);
				1: issue_step("chain", r_type(7'h20, 5'd21, 5'd20, SUB, 5'd21), null_word);
				2: issue_step("chain", r_type(7'h00, 5'd20, 5'd21, XOR, 5'd20), null_word);
				default: issue_step("chain", i_type(I, 32'd1, 5'd20, SLLI, 5'd21), 32'd1);
			endcase
		end
		drain();
	endtask

	initial begin
		rst_n       = 1'b0;
		issue_valid = 1'b0;
		issue       = '0;
		pend_valid  = 1'b0;
		pend_name   = "";
		pend_wb     = '0;
		pend_mem    = '0;
		cur_pc      = 32'h0000_1000;
		lfsr_state  = 32'h53be_6632;
		for (int r = 0; r < 32; r++)
			model_regs[r] = null_word;
		repeat (reset_cycles) @(posedge clk);
		#1;
		rst_n = 1'b1;
		reset_state();
		seed_and_rtype();
		itype_ops();
		pc_relative();
		no_write_ops();
		dependency_chain();
		$display("All tests passed");
		$finish;
	end

endmodule

// File: files.f
rv_isa_pkg.sv
exec_pkg.sv
exec_ctrl.sv
imm_gen.sv
regfile.sv
alu.sv
exec_core.sv
tb_exec_core.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the execute subsystem testbench with verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary -f files.f --top-module tb_exec_core -o sim_exec_core \
	&& ./obj_dir/sim_exec_core 2>&1 | tee sim.log
grep -q "Some tests failed" sim.log && { echo "simulation reported failure"; exit 1; }
grep -q "All tests passed" sim.log || { echo "simulation did not complete"; exit 1; }
exit 0
